// File: Makefile
# Verilator simulation of the cpuDataPath testbench
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= cpuDataPathTb
FILELIST  ?= cpuDataPath.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -Wno-fatal
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cpuDataPath.f
+incdir+verilog
verilog/cpuDataPathPkg.sv
verilog/dlBusIf.sv
verilog/instrDecoder.sv
verilog/aluCore.sv
verilog/dataMux.sv
verilog/cpuDataPath.sv
verification/cpuDataPathTb.sv

// File: verification/busCases.txt
// Columns: busDisable flag, byte offered on dataIn (hex)
// A row with flag FF ends the list
00 01 // LD
00 5A
00 07 // ST
00 07 // ST back to back
00 02 // ADD with carry out
00 C0
00 87 // ST, upper opcode bits ignored
00 03 // SUB to zero
00 1A
00 03 // SUB with borrow
00 01
00 01 // LD keeps the borrow
00 33
00 04 // AND to zero, carry cleared
00 0C
00 05 // OR
00 F0
00 06 // XOR
00 FF
00 07 // ST
01 01 // Ignored LD
01 22
00 07 // ST, dropped by the next row
01 00
00 07 // ST
00 00 // NOP
FF FF

// File: verification/cpuDataPathTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpuDataPath_params.svh"

module cpuDataPathTb;
	import cpuDataPathPkg::*;

	localparam int RandomBytes = 200;
	localparam int MaxRows     = 64;

	logic       CLK;
	logic       arstN;
	logic       busDisable;
	busByteT    dataIn;
	logic       dataInStrobe;
	busByteT    dataOut;
	logic       dataOutValid;
	logic       zeroFlag;
	logic       carryFlag;

	busByteT    caseWords [0:2*MaxRows-1]; // Flag and byte per row
	int         rowCount;
	int         cycleCount  = 0;
	int         cycleLimit  = 0;           // Zero until the case file is read
	int         valueErrors = 0;
	int         otherErrors = 0;
	integer     seed;
	logic [31:0] randByte;
	logic [31:0] randDisable;

	decStateT   mState;       // Model decoder
	aluOpT      mOp;
	busByteT    mAcc;
	logic       mZero;
	logic       mCarry;
	logic       storePending; // ST seen, bus state of next cycle decides
	busByteT    storeValue;
	busByteT    expectQ [$];
	logic [1:0] zeroHist;     // Model flags one and two steps back
	logic [1:0] carryHist;

	cpuDataPath DUT (
		.CLK          (CLK),
		.arstN        (arstN),
		.busDisable   (busDisable),
		.dataIn       (dataIn),
		.dataInStrobe (dataInStrobe),
		.dataOut      (dataOut),
		.dataOutValid (dataOutValid),
		.zeroFlag     (zeroFlag),
		.carryFlag    (carryFlag)
	);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	// Watchdog
	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles, %0d outputs never appeared",
				cycleCount, expectQ.size());
			$display("valueErrors %0d otherErrors %0d", valueErrors, otherErrors + 1);
			$display("Some tests failed");
			$finish;
		end
	end

	// Accumulator and flag rules for one operand
	task automatic applyOp(input aluOpT op, input busByteT operand);
		case (op)
			LD: mAcc = operand; // Carry kept
			ADD: begin
				mCarry = (int'(mAcc) + int'(operand)) > 255;
				mAcc   = mAcc + operand;
			end
			SUB: begin
				mCarry = operand > mAcc; // Borrow
				mAcc   = mAcc - operand;
			end
			AND: begin
				mAcc   = mAcc & operand;
				mCarry = 1'b0;
			end
			OR: begin
				mAcc   = mAcc | operand;
				mCarry = 1'b0;
			end
			XOR: begin
				mAcc   = mAcc ^ operand;
				mCarry = 1'b0;
			end
			default: mAcc = mAcc;
		endcase
		mZero = (mAcc == 8'h00);
	endtask

	// Model one offered cycle
	task automatic modelStep(input logic dis, input busByteT b, input logic strobe);
		aluOpT op;
		if (storePending && !dis)
			expectQ.push_back(storeValue); // Store cycle had the bus
		storePending = 1'b0;
		if (strobe && !dis) begin
			if (mState == WaitOpcode) begin
				op = aluOpT'(b[2:0]);
				if (op == ST) begin
					storePending = 1'b1;
					storeValue   = mAcc;
				end
				else if (op != NOP) begin
					mOp    = op;
					mState = WaitOperand;
				end
			end
			else begin
				applyOp(mOp, b);
				mState = WaitOpcode;
			end
		end
	endtask

	// Outputs are registered, so they are stable at the falling edge
	task automatic checkOutputs;
		busByteT expected;
		if (dataOutValid === 1'b1) begin
			assert (expectQ.size() > 0) else begin
				otherErrors++;
				$display("Output %h appeared with no store expected", dataOut);
			end
			if (expectQ.size() > 0) begin
				expected = expectQ.pop_front();
				assert (dataOut === expected) else begin
					valueErrors++;
					$display("error: dataOut expected %h observed %h", expected, dataOut);
				end
			end
		end
		else begin
			assert (dataOutValid === 1'b0) else begin
				valueErrors++;
				$display("error: dataOutValid expected 0 observed %h", dataOutValid);
			end
			assert (dataOut === `BUS_IDLE) else begin
				valueErrors++;
				$display("error: dataOut expected %h observed %h", `BUS_IDLE, dataOut);
			end
		end
		assert (zeroFlag === zeroHist[1]) else begin
			valueErrors++;
			$display("error: zeroFlag expected %h observed %h", zeroHist[1], zeroFlag);
		end
		assert (carryFlag === carryHist[1]) else begin
			valueErrors++;
			$display("error: carryFlag expected %h observed %h", carryHist[1], carryFlag);
		end
	endtask

	// Check, then drive one cycle on the falling edge
	task automatic offerByte(input logic dis, input busByteT b, input logic strobe);
		@(negedge CLK);
		checkOutputs();
		busDisable   = dis;
		dataIn       = b;
		dataInStrobe = strobe;
		modelStep(dis, b, strobe);
		zeroHist  = {zeroHist[0], mZero};   // DUT flags trail by two cycles
		carryHist = {carryHist[0], mCarry};
	endtask

	initial begin
		arstN        = 1'b0;
		busDisable   = 1'b0;
		dataIn       = '0;
		dataInStrobe = 1'b0;
		seed         = 32'h9e9a;
		mState       = WaitOpcode;
		mOp          = NOP;
		mAcc         = '0;
		mZero        = 1'b1;
		mCarry       = 1'b0;
		storePending = 1'b0;
		storeValue   = '0;
		zeroHist     = 2'b11;
		carryHist    = 2'b00;

		$readmemh("verification/busCases.txt", caseWords);
		rowCount = 0;
		while (rowCount < MaxRows && caseWords[2*rowCount] != 8'hFF)
			rowCount++;
		cycleLimit = 4 * (rowCount + RandomBytes) + 50;

		repeat (4) @(posedge CLK);
		@(negedge CLK);
		arstN = 1'b1;

		// Directed rows, one byte per cycle
		for (int i = 0; i < rowCount; i++)
			offerByte(caseWords[2*i][0], caseWords[2*i+1], 1'b1);

		// Random stream, bus disabled about one cycle in sixteen
		for (int i = 0; i < RandomBytes; i++) begin
			randByte    = $random(seed);
			randDisable = $random(seed);
			offerByte(randDisable[3:0] == 4'h0, randByte[7:0], 1'b1);
		end

		// Drain, then a few idle cycles for stray outputs and final flags
		while (expectQ.size() > 0 || storePending)
			offerByte(1'b0, 8'h00, 1'b0);
		repeat (3) offerByte(1'b0, 8'h00, 1'b0);

		$display("valueErrors %0d otherErrors %0d", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/aluCore.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpuDataPath_params.svh"

module aluCore (
	input wire   CLK,       // Core clock
	input wire   arstN,     // Async reset, active low
	dlBusIf.alu  bus,
	output logic zeroFlag,  // Last executed result was zero
	output logic carryFlag  // Carry or borrow of the last arithmetic op
);
	import cpuDataPathPkg::*;

	busByteT              accumulator;
	busByteT              accNext;   // Result of the current operation
	logic                 carryNext;
	logic [`DATA_WIDTH:0] sumWide;   // One extra bit for the carry
	logic [`DATA_WIDTH:0] diffWide;  // Top bit is the borrow

	assign sumWide  = {1'b0, accumulator} + {1'b0, bus.dl};
	assign diffWide = {1'b0, accumulator} - {1'b0, bus.dl};

	always_comb begin
		accNext   = accumulator;
		carryNext = carryFlag; // Held unless the op says otherwise

		case (bus.aluOp)
			LD: begin
				accNext = bus.dl; // Carry untouched
			end
			ADD: begin
				accNext   = sumWide[`DATA_WIDTH-1:0];
				carryNext = sumWide[`DATA_WIDTH];
			end
			SUB: begin
				accNext   = diffWide[`DATA_WIDTH-1:0];
				carryNext = diffWide[`DATA_WIDTH];
			end
			AND: begin
				accNext   = accumulator & bus.dl;
				carryNext = 1'b0;
			end
			OR: begin
				accNext   = accumulator | bus.dl;
				carryNext = 1'b0;
			end
			XOR: begin
				accNext   = accumulator ^ bus.dl;
				carryNext = 1'b0;
			end
			default: begin
				// NOP and ST never come with execute
				accNext = accumulator;
			end
		endcase
	end

	// State only moves on an execute strobe
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			accumulator <= '0;
			zeroFlag    <= 1'b1; // Matches the cleared accumulator
			carryFlag   <= 1'b0;
		end
		else if (bus.execute) begin
			accumulator <= accNext;
			carryFlag   <= carryNext;
			zeroFlag    <= (accNext == '0);
		end
	end

	assign bus.dv = accumulator; // Operand path toward the result stage

endmodule

`default_nettype wire

// File: verilog/cpuDataPath.sv
`timescale 1ns/100ps
`default_nettype none

module cpuDataPath (
	input wire                          CLK,          // Core clock
	input wire                          arstN,        // Async reset, active low
	input wire                          busDisable,   // Test input
	input wire cpuDataPathPkg::busByteT dataIn,       // External bus in
	input wire                          dataInStrobe, // One cycle per byte
	output cpuDataPathPkg::busByteT     dataOut,      // External bus out, FF when idle
	output logic                        dataOutValid, // Store result present
	output logic                        zeroFlag,
	output logic                        carryFlag
);

	// DL bus and strobes shared by the three stages
	dlBusIf dlBus ();

	// Decode
	instrDecoder decoder (
		.CLK   (CLK),
		.arstN (arstN),
		.bus   (dlBus.decoder)
	);

	// Execute
	aluCore alu (
		.CLK       (CLK),
		.arstN     (arstN),
		.bus       (dlBus.alu),
		.zeroFlag  (zeroFlag),
		.carryFlag (carryFlag)
	);

	// Result, the only block that touches the external bus
	dataMux mux (
		.CLK          (CLK),
		.arstN        (arstN),
		.busDisable   (busDisable),
		.dataIn       (dataIn),
		.dataInStrobe (dataInStrobe),
		.dataOut      (dataOut),
		.dataOutValid (dataOutValid),
		.bus          (dlBus.mux)
	);

endmodule

`default_nettype wire

// File: verilog/cpuDataPathPkg.sv
`default_nettype none

`include "cpuDataPath_params.svh"

package cpuDataPathPkg;

	// Any byte on DL, on the external bus or held in the accumulator
	typedef logic [`DATA_WIDTH-1:0] busByteT;

	// Operation field in the low opcode bits
	typedef enum logic [`ALU_OP_WIDTH-1:0] {
		NOP = 3'd0, // No operand, no effect
		LD  = 3'd1, // Accumulator <= operand
		ADD = 3'd2, // Carry out of the top bit
		SUB = 3'd3, // Carry holds the borrow
		AND = 3'd4,
		OR  = 3'd5,
		XOR = 3'd6,
		ST  = 3'd7  // Accumulator out to the external bus
	} aluOpT;

	// Decoder position within an instruction
	typedef enum logic {
		WaitOpcode  = 1'b0, // Next DL byte is an opcode
		WaitOperand = 1'b1  // Next DL byte feeds the ALU
	} decStateT;

endpackage

`default_nettype wire

// File: verilog/cpuDataPath_params.svh
`ifndef CPU_DATA_PATH_PARAMS_SVH
`define CPU_DATA_PATH_PARAMS_SVH

// Width of the external data bus, the internal DL bus and the accumulator
// The core is byte oriented, so opcode and operand both fit one bus word
`define DATA_WIDTH 8

// Value left on a bus that nobody drives
// The real part precharges both buses high while the clock is low
`define BUS_IDLE {`DATA_WIDTH{1'b1}}

// Only the low bits of an opcode select the operation
`define ALU_OP_WIDTH 3

// Upper opcode bits are don't care
// NOP and ST carry no operand byte
// LD, ADD, SUB, AND, OR and XOR take exactly one operand byte

`endif

// File: verilog/dataMux.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpuDataPath_params.svh"

module dataMux (
	input wire                          CLK,          // Core clock
	input wire                          arstN,        // Async reset, active low
	input wire                          busDisable,   // Test input, core cut off from the bus
	input wire cpuDataPathPkg::busByteT dataIn,       // External bus, inbound
	input wire                          dataInStrobe, // dataIn holds a byte this cycle
	output cpuDataPathPkg::busByteT     dataOut,      // External bus, outbound
	output logic                        dataOutValid, // One cycle per store
	dlBusIf.mux                         bus
);
	import cpuDataPathPkg::*;

	busByteT extToIntQ;  // External bus latch toward DL
	logic    dlValidQ;
	busByteT intToExtQ;  // DV latch toward the external bus
	logic    outValidQ;
	logic    acceptIn;   // Inbound byte is taken
	logic    acceptOut;  // Store reaches the external bus

	// Bus disable blocks both directions
	assign acceptIn  = dataInStrobe & ~busDisable;
	assign acceptOut = bus.store & ~busDisable;

	// Payload latches
	always_ff @(posedge CLK) begin
		if (acceptIn)
			extToIntQ <= dataIn;
		if (acceptOut)
			intToExtQ <= bus.dv; // Accumulator as seen in the store cycle
	end

	// Valid flags
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			dlValidQ  <= 1'b0;
			outValidQ <= 1'b0;
		end
		else begin
			dlValidQ  <= acceptIn;  // Pulse, one cycle per accepted byte
			outValidQ <= acceptOut;
		end
	end

	// Undriven buses float to the precharge value
	assign bus.dl      = dlValidQ ? extToIntQ : `BUS_IDLE;
	assign bus.dlValid = dlValidQ;

	assign dataOut      = outValidQ ? intToExtQ : `BUS_IDLE;
	assign dataOutValid = outValidQ;

endmodule

`default_nettype wire

// File: verilog/dlBusIf.sv
`timescale 1ns/100ps
`default_nettype none

// Internal DL bus plus the strobes between decode, execute and result
interface dlBusIf;
	import cpuDataPathPkg::*;

	busByteT dl;      // Internal data bus, idle value when nothing is latched
	logic    dlValid; // One cycle, DL holds a fresh byte from outside
	aluOpT   aluOp;   // Operation for the pending operand
	logic    execute; // One cycle, ALU consumes DL
	logic    store;   // One cycle, accumulator goes out
	busByteT dv;      // Accumulator value toward the bus

	// Result stage owns DL
	modport mux (output dl, output dlValid, input store, input dv);

	// Decode stage reads DL and issues the strobes
	modport decoder (input dl, input dlValid, output aluOp, output execute, output store);

	// Execute stage
	modport alu (input dl, input aluOp, input execute, output dv);

endinterface

`default_nettype wire

// File: verilog/instrDecoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpuDataPath_params.svh"

module instrDecoder (
	input wire      CLK,   // Core clock
	input wire      arstN, // Async reset, active low
	dlBusIf.decoder bus
);
	import cpuDataPathPkg::*;

	decStateT state;      // Current position in the instruction
	decStateT stateNext;
	aluOpT    heldOp;     // Operation waiting for its operand
	aluOpT    heldOpNext;
	aluOpT    opcodeOp;   // DL read as an opcode
	logic     executeNext;
	logic     storeNext;

	// Bits above the operation field are ignored
	assign opcodeOp = aluOpT'(bus.dl[`ALU_OP_WIDTH-1:0]);

	// No register between dlValid and the strobes
	always_comb begin
		stateNext   = state;
		heldOpNext  = heldOp;
		executeNext = 1'b0;
		storeNext   = 1'b0;

		case (state)
			WaitOpcode: begin
				if (bus.dlValid) begin
					case (opcodeOp)
						NOP: begin
							// Consumed without any effect
							stateNext = WaitOpcode;
						end
						ST: begin
							storeNext = 1'b1; // No operand follows
						end
						default: begin
							heldOpNext = opcodeOp;   // Remember for the operand
							stateNext  = WaitOperand;
						end
					endcase
				end
			end

			WaitOperand: begin
				if (bus.dlValid) begin
					executeNext = 1'b1;  // Operand is on DL right now
					stateNext   = WaitOpcode;
				end
			end
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state  <= WaitOpcode;
			heldOp <= NOP;
		end
		else begin
			state  <= stateNext;
			heldOp <= heldOpNext;
		end
	end

	// Strobes are combinational pulses in the dlValid cycle
	assign bus.execute = executeNext;
	assign bus.store   = storeNext;

	// Operation stays stable for the whole operand wait
	assign bus.aluOp = heldOp;

endmodule

`default_nettype wire
